// ==== debug_patterns.txt ====
// first word: number of program words, then the program (halt has the top six bits set)
// after the program: command entries {cmd byte, argument byte}, 0 ends the list
00000006
20010005
20020007
00221820
ac030004
8c040004
fc000000
// load, unknown byte, run, step mode with 4 steps
00000100
00000700
00000200
00000304
// step and exit bytes while idle, then a second run
00000400
00000500
00000200
00000000

// ==== src.f ====
+incdir+.
debug_cmd_pkg.sv
cpu_view_pkg.sv
load_inst_fsm.sv
run_fsm.sv
step_fsm.sv
send_data_fsm.sv
debug_fsm.sv
tb_debug_fsm.sv

// ==== Bender.yml ====
package:
  name: debug_fsm

export_include_dirs:
  - .

sources:
  - debug_cmd_pkg.sv
  - cpu_view_pkg.sv
  - load_inst_fsm.sv
  - run_fsm.sv
  - step_fsm.sv
  - send_data_fsm.sv
  - debug_fsm.sv
  - target: simulation
    files:
      - tb_debug_fsm.sv

// ==== tb_debug_fsm.sv ====
`default_nettype none

`include "debug_params.svh"

module tb_debug_fsm
    import debug_cmd_pkg::*;
    import cpu_view_pkg::*;
;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT     = 5000;
    localparam int PAT_WORDS   = 64;
    localparam int COUNT_BYTES = `CLK_COUNT_BITS / `UART_BITS;
    localparam int DUMP_WORDS  = 1 + `NUM_REGS + 4 + `DUMP_MEM_WORDS;
    localparam int DUMP_BYTES  = COUNT_BYTES + 4 * (DUMP_WORDS - 1);

    logic                       clk = 1'b0;
    logic                       rst;
    logic [`UART_BITS-1:0]      i_rx_data;
    logic                       i_rx_done;
    logic                       i_tx_done;
    cpu_snapshot_t              i_snapshot;
    logic [`PROC_BITS-1:0]      i_mem_data;
    logic                       o_enable;
    logic                       o_rst_cpu;
    logic                       o_imem_wr_valid;
    imem_write_t                o_imem_wr;
    logic                       o_dbg_mem_rd;
    logic [`DATA_ADDR_BITS-1:0] o_dbg_mem_addr;
    logic                       o_tx_start;
    logic [`UART_BITS-1:0]      o_tx_data;
    debug_state_e               o_state;

    logic [31:0]           pat [0:PAT_WORDS-1];
    logic [`INST_BITS-1:0] imem [0:255];
    logic [`PC_BITS-1:0]   pc = '0;
    logic [`INST_BITS-1:0] if_id = '0;
    logic [7:0]            tx_q [$];
    logic [31:0]           lcg_state = 32'd62;
    int                    enable_cnt = 0;
    int                    wr_cnt = 0;
    int                    tx_delay = 0;
    logic                  tx_busy = 1'b0;
    int                    checks = 0;
    int                    errors = 0;

    // output samples taken at the falling edge
    logic                       s_enable;
    logic                       s_rst_cpu;
    logic                       s_wr_valid;
    imem_write_t                s_wr;
    logic                       s_mem_rd;
    logic [`DATA_ADDR_BITS-1:0] s_mem_addr;
    logic                       s_tx_start;
    logic [`UART_BITS-1:0]      s_tx_data;

    debug_fsm dut0 (
        .clk             (clk),
        .rst             (rst),
        .i_rx_data       (i_rx_data),
        .i_rx_done       (i_rx_done),
        .i_tx_done       (i_tx_done),
        .i_snapshot      (i_snapshot),
        .i_mem_data      (i_mem_data),
        .o_enable        (o_enable),
        .o_rst_cpu       (o_rst_cpu),
        .o_imem_wr_valid (o_imem_wr_valid),
        .o_imem_wr       (o_imem_wr),
        .o_dbg_mem_rd    (o_dbg_mem_rd),
        .o_dbg_mem_addr  (o_dbg_mem_addr),
        .o_tx_start      (o_tx_start),
        .o_tx_data       (o_tx_data),
        .o_state         (o_state)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // registers, latches and data words of the processor model
    function automatic logic [31:0] state_word(input logic [7:0] tag, input logic [7:0] idx,
                                               input logic [7:0] pc_v);
        return {tag + idx, pc_v ^ 8'h5a, ~pc_v, pc_v * 8'd3 + idx};
    endfunction

    // word i of the dump when the processor stands at pc p
    function automatic logic [31:0] dump_word(input int i, input int cnt, input int p);
        if (i == 0)
            return cnt & 32'hffff;
        if (i <= `NUM_REGS)
            return state_word(8'h20, 8'(i - 1), 8'(p));
        if (i == `NUM_REGS + 1)
            return (p == 0) ? 32'h0 : pat[p];
        if (i <= `NUM_REGS + 4)
            return state_word(8'h30, 8'(i - `NUM_REGS - 1), 8'(p));
        return state_word(8'h40, 8'(i - `NUM_REGS - 5), 8'(p));
    endfunction

    task automatic finish_report();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("error at %0t: %s", $time, why);
        finish_report();
    endtask

    task automatic note_failure(input string why);
        errors++;
        $display("error at %0t: %s", $time, why);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_state(input debug_state_e want, input string what);
        int n;
        n = 0;
        while (o_state !== want && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (o_state !== want)
            abort_run({"timed out waiting for ", what});
    endtask

    task automatic wait_dump();
        int n;
        n = 0;
        while ((tx_q.size() < DUMP_BYTES || tx_busy) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (tx_q.size() < DUMP_BYTES || tx_busy) begin
            abort_run("timed out waiting for a complete dump");
        end else begin
            // send_done and the step machine each take one more cycle
            repeat (3) @(negedge clk);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        #DRIVE_DELAY;
        i_rx_data = b;
        i_rx_done = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        i_rx_done = 1'b0;
        // uart byte gap
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_dump(input int cnt, input int p);
        logic [31:0] w;
        int n;
        int nb;
        n = 0;
        for (int i = 0; i < DUMP_WORDS; i++) begin
            w = dump_word(i, cnt, p);
            nb = (i == 0) ? COUNT_BYTES : 4;
            for (int b = nb - 1; b >= 0; b--) begin
                if (n < tx_q.size())
                    check(tx_q[n], w[b*8 +: 8], $sformatf("dump byte %0d", n));
                n++;
            end
        end
        check(tx_q.size(), DUMP_BYTES, "dump length");
        tx_q.delete();
    endtask

    task automatic load_program(input int halt_addr);
        logic [31:0] w;
        wr_cnt = 0;
        send_byte(`CMD_LOAD);
        wait_state(wait_load, "the load to start");
        for (int a = 0; a <= halt_addr; a++) begin
            w = pat[1 + a];
            for (int b = 3; b >= 0; b--)
                send_byte(w[b*8 +: 8]);
        end
        wait_state(idle, "the end of the load");
        check(wr_cnt, halt_addr + 1, "instruction words written");
    endtask

    task automatic run_program(input int halt_addr);
        enable_cnt = 0;
        tx_q.delete();
        send_byte(`CMD_RUN);
        wait_state(idle, "the end of a run");
        check(enable_cnt, halt_addr + 1, "enable cycles of a run");
        check_dump(halt_addr + 1, halt_addr + 1);
    endtask

    task automatic step_program(input int steps);
        tx_q.delete();
        send_byte(`CMD_STEP_MODE);
        wait_state(wait_step, "step mode");
        for (int k = 1; k <= steps; k++) begin
            enable_cnt = 0;
            send_byte(`CMD_STEP);
            wait_dump();
            check(enable_cnt, 1, $sformatf("enable cycles of step %0d", k));
            check_dump(k, k);
        end
        send_byte(`CMD_EXIT);
        wait_state(idle, "the end of step mode");
    endtask

    task automatic send_unknown(input logic [7:0] b);
        enable_cnt = 0;
        wr_cnt = 0;
        tx_q.delete();
        send_byte(b);
        repeat (4) begin
            check(o_state, idle, "state after an unknown command");
            @(negedge clk);
        end
        check(enable_cnt, 0, "enable cycles after an unknown command");
        check(wr_cnt, 0, "memory writes after an unknown command");
        check(tx_q.size(), 0, "bytes sent after an unknown command");
    endtask

    task automatic drive_snapshot();
        for (int i = 0; i < `NUM_REGS; i++)
            i_snapshot.rf_regs[i] = state_word(8'h20, 8'(i), pc);
        i_snapshot.if_id  = if_id;
        i_snapshot.id_ex  = state_word(8'h30, 8'd1, pc);
        i_snapshot.ex_mem = state_word(8'h30, 8'd2, pc);
        i_snapshot.mem_wb = state_word(8'h30, 8'd3, pc);
    endtask

    // processor and uart models act just after each rising edge
    always begin
        @(negedge clk);
        s_enable   = o_enable;
        s_rst_cpu  = o_rst_cpu;
        s_wr_valid = o_imem_wr_valid;
        s_wr       = o_imem_wr;
        s_mem_rd   = o_dbg_mem_rd;
        s_mem_addr = o_dbg_mem_addr;
        s_tx_start = o_tx_start;
        s_tx_data  = o_tx_data;
        @(posedge clk);
        #DRIVE_DELAY;
        i_tx_done = 1'b0;
        if (s_wr_valid === 1'b1) begin
            check(s_wr.addr, wr_cnt, "instruction write address");
            check(s_wr.data, pat[1 + wr_cnt], "instruction write data");
            imem[s_wr.addr] = s_wr.data;
            wr_cnt++;
        end
        if (s_enable === 1'b1)
            enable_cnt++;
        if (s_rst_cpu === 1'b0) begin
            pc    = '0;
            if_id = '0;
        end else if (s_enable === 1'b1) begin
            if_id = imem[pc];
            pc    = pc + 1'b1;
        end
        drive_snapshot();
        if (s_mem_rd === 1'b1)
            i_mem_data = state_word(8'h40, 8'(s_mem_addr), pc);
        if (s_tx_start === 1'b1) begin
            if (tx_busy)
                note_failure("a byte was started before the previous one finished");
            tx_q.push_back(s_tx_data);
            lcg_state = lcg_next(lcg_state);
            tx_delay  = 1 + int'(lcg_state[18:16]);
            tx_busy   = 1'b1;
        end
        if (tx_busy) begin
            tx_delay--;
            if (tx_delay == 0) begin
                i_tx_done = 1'b1;
                tx_busy   = 1'b0;
            end
        end
    end

    initial begin
        int n_prog;
        int idx;
        int halt_addr;
        logic [7:0] cmd;
        logic [7:0] arg;
        rst        = 1'b0;
        i_rx_data  = '0;
        i_rx_done  = 1'b0;
        i_tx_done  = 1'b0;
        i_snapshot = '0;
        i_mem_data = '0;
        for (int a = 0; a < 256; a++)
            imem[a] = {24'h0000a5, 8'(a)};
        for (int a = 0; a < PAT_WORDS; a++)
            pat[a] = '0;
        $readmemh("debug_patterns.txt", pat);
        n_prog    = pat[0];
        halt_addr = -1;
        for (int a = 0; a < n_prog; a++)
            if (halt_addr < 0 && pat[1 + a][31 -: `OPCODE_BITS] == `HALT_OPCODE)
                halt_addr = a;
        if (halt_addr < 0)
            note_failure("the pattern file holds no halt instruction");

        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        @(negedge clk);
        check(o_state, idle, "state after reset");
        check(o_tx_start, 1'b0, "tx start after reset");
        check(o_enable, 1'b0, "enable after reset");
        check(o_imem_wr_valid, 1'b0, "instruction write after reset");
        check(o_dbg_mem_rd, 1'b0, "memory read after reset");
        check(o_rst_cpu, 1'b0, "processor reset after reset");

        idx = 1 + n_prog;
        while (idx < PAT_WORDS && pat[idx] !== 32'h0) begin
            cmd = pat[idx][15:8];
            arg = pat[idx][7:0];
            case (cmd)
                `CMD_LOAD:      load_program(halt_addr);
                `CMD_RUN:       run_program(halt_addr);
                `CMD_STEP_MODE: step_program(arg);
                default:        send_unknown(cmd);
            endcase
            idx++;
        end
        finish_report();
    end

endmodule

`default_nettype wire

// ==== debug_fsm.sv ====
`default_nettype none

`include "debug_params.svh"

module debug_fsm
    import debug_cmd_pkg::*;
    import cpu_view_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`UART_BITS-1:0]      i_rx_data,
    input  logic                       i_rx_done,
    input  logic                       i_tx_done,
    input  cpu_snapshot_t              i_snapshot,
    input  logic [`PROC_BITS-1:0]      i_mem_data,
    output logic                       o_enable,
    output logic                       o_rst_cpu,
    output logic                       o_imem_wr_valid,
    output imem_write_t                o_imem_wr,
    output logic                       o_dbg_mem_rd,
    output logic [`DATA_ADDR_BITS-1:0] o_dbg_mem_addr,
    output logic                       o_tx_start,
    output logic [`UART_BITS-1:0]      o_tx_data,
    output debug_state_e               o_state
);

    debug_state_e state;
    debug_state_e next_state;

    logic load_done;
    logic run_enable;
    logic run_send_start;
    logic run_done;
    logic step_enable;
    logic step_send_start;
    logic step_done;
    logic send_start;
    logic send_done;

    logic [`CLK_COUNT_BITS-1:0] run_clk_count;
    logic [`CLK_COUNT_BITS-1:0] step_clk_count;
    logic [`CLK_COUNT_BITS-1:0] clk_count;

    always_ff @(posedge clk) begin
        if (!rst)
            state <= idle;
        else
            state <= next_state;
    end

    // commands are only decoded while idle
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (i_rx_done) begin
                    case (debug_cmd_e'(i_rx_data))
                        cmd_load:      next_state = start_load;
                        cmd_run:       next_state = start_run;
                        cmd_step_mode: next_state = start_step;
                        default:       next_state = idle;
                    endcase
                end
            end
            start_load: next_state = wait_load;
            start_run:  next_state = wait_run;
            start_step: next_state = wait_step;
            wait_load:  if (load_done) next_state = idle;
            wait_run:   if (run_done)  next_state = idle;
            wait_step:  if (step_done) next_state = idle;
            default:    next_state = idle;
        endcase
    end

    assign o_state   = state;
    assign o_rst_cpu = (state != idle);

    // only the active machine reaches the processor and the dump
    always_comb begin
        o_enable   = 1'b0;
        send_start = 1'b0;
        clk_count  = '0;
        if (state == wait_run) begin
            o_enable   = run_enable;
            send_start = run_send_start;
            clk_count  = run_clk_count;
        end else if (state == wait_step) begin
            o_enable   = step_enable;
            send_start = step_send_start;
            clk_count  = step_clk_count;
        end
    end

    load_inst_fsm load0 (
        .clk             (clk),
        .rst             (rst),
        .i_start         (state == start_load),
        .i_rx_done       (i_rx_done),
        .i_rx_data       (i_rx_data),
        .o_imem_wr_valid (o_imem_wr_valid),
        .o_imem_wr       (o_imem_wr),
        .o_done          (load_done)
    );

    run_fsm run0 (
        .clk           (clk),
        .rst           (rst),
        .i_start       (state == start_run),
        .i_send_done   (send_done),
        .i_instruction (i_snapshot.if_id),
        .o_enable      (run_enable),
        .o_send_start  (run_send_start),
        .o_clk_count   (run_clk_count),
        .o_done        (run_done)
    );

    step_fsm step0 (
        .clk           (clk),
        .rst           (rst),
        .i_start       (state == start_step),
        .i_rx_done     (i_rx_done),
        .i_rx_data     (i_rx_data),
        .i_instruction (i_snapshot.if_id),
        .i_send_done   (send_done),
        .o_enable      (step_enable),
        .o_send_start  (step_send_start),
        .o_clk_count   (step_clk_count),
        .o_done        (step_done)
    );

    send_data_fsm send0 (
        .clk            (clk),
        .rst            (rst),
        .i_start        (send_start),
        .i_tx_done      (i_tx_done),
        .i_snapshot     (i_snapshot),
        .i_mem_data     (i_mem_data),
        .i_clk_count    (clk_count),
        .o_dbg_mem_rd   (o_dbg_mem_rd),
        .o_dbg_mem_addr (o_dbg_mem_addr),
        .o_tx_start     (o_tx_start),
        .o_tx_data      (o_tx_data),
        .o_done         (send_done)
    );

endmodule

`default_nettype wire

// ==== send_data_fsm.sv ====
`default_nettype none

`include "debug_params.svh"

module send_data_fsm
    import debug_cmd_pkg::*;
    import cpu_view_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_start,
    input  logic                       i_tx_done,
    input  cpu_snapshot_t              i_snapshot,
    input  logic [`PROC_BITS-1:0]      i_mem_data,
    input  logic [`CLK_COUNT_BITS-1:0] i_clk_count,
    output logic                       o_dbg_mem_rd,
    output logic [`DATA_ADDR_BITS-1:0] o_dbg_mem_addr,
    output logic                       o_tx_start,
    output logic [`UART_BITS-1:0]      o_tx_data,
    output logic                       o_done
);

    // word order: count, registers, four latches, data memory
    localparam logic [4:0] LATCH_BASE = 5'(1 + `NUM_REGS);
    localparam logic [4:0] MEM_BASE   = LATCH_BASE + 5'd4;
    localparam logic [4:0] LAST_WORD  = MEM_BASE + 5'(`DUMP_MEM_WORDS - 1);
    localparam logic [1:0] COUNT_TOP  = 2'(`CLK_COUNT_BITS / `UART_BITS - 1);
    localparam int         REG_BITS   = $clog2(`NUM_REGS);

    send_state_e                state;
    cpu_snapshot_t              snap;
    logic [`CLK_COUNT_BITS-1:0] count;
    logic [`PROC_BITS-1:0]      cur_word;
    logic [`PROC_BITS-1:0]      sel_word;
    logic [4:0]                 word_idx;
    logic [1:0]                 byte_idx;

    always_comb begin
        case (word_idx)
            5'd0:            sel_word = `PROC_BITS'(count);
            LATCH_BASE:      sel_word = snap.if_id;
            LATCH_BASE + 1:  sel_word = snap.id_ex;
            LATCH_BASE + 2:  sel_word = snap.ex_mem;
            LATCH_BASE + 3:  sel_word = snap.mem_wb;
            default:         sel_word = snap.rf_regs[REG_BITS'(word_idx - 5'd1)];
        endcase
    end

    assign o_dbg_mem_rd   = (state == sd_fetch) && (word_idx >= MEM_BASE);
    assign o_dbg_mem_addr = `DATA_ADDR_BITS'(word_idx - MEM_BASE);
    assign o_tx_start     = (state == sd_send);
    assign o_tx_data      = cur_word[byte_idx*`UART_BITS +: `UART_BITS];
    assign o_done         = (state == sd_done);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= sd_idle;
            word_idx <= '0;
            byte_idx <= '0;
        end else begin
            case (state)
                sd_idle: begin
                    if (i_start) begin
                        state    <= sd_fetch;
                        word_idx <= '0;
                    end
                end
                sd_fetch: begin
                    // memory words arrive a cycle after the read
                    if (word_idx >= MEM_BASE) begin
                        state <= sd_mem;
                    end else begin
                        state    <= sd_send;
                        byte_idx <= (word_idx == 5'd0) ? COUNT_TOP : 2'd3;
                    end
                end
                sd_mem: begin
                    state    <= sd_send;
                    byte_idx <= 2'd3;
                end
                sd_send: state <= sd_wait;
                sd_wait: begin
                    if (i_tx_done) begin
                        if (byte_idx != 2'd0) begin
                            byte_idx <= byte_idx - 2'd1;
                            state    <= sd_send;
                        end else if (word_idx == LAST_WORD) begin
                            state <= sd_done;
                        end else begin
                            word_idx <= word_idx + 5'd1;
                            state    <= sd_fetch;
                        end
                    end
                end
                default: state <= sd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sd_idle && i_start) begin
            snap  <= i_snapshot;
            count <= i_clk_count;
        end
        if (state == sd_fetch)
            cur_word <= sel_word;
        else if (state == sd_mem)
            cur_word <= i_mem_data;
    end

endmodule

`default_nettype wire

// ==== step_fsm.sv ====
`default_nettype none

`include "debug_params.svh"

module step_fsm
    import debug_cmd_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_start,
    input  logic                       i_rx_done,
    input  logic [`UART_BITS-1:0]      i_rx_data,
    input  logic [`INST_BITS-1:0]      i_instruction,
    input  logic                       i_send_done,
    output logic                       o_enable,
    output logic                       o_send_start,
    output logic [`CLK_COUNT_BITS-1:0] o_clk_count,
    output logic                       o_done
);

    step_state_e state;
    logic        is_halt;
    logic        exit_cmd;
    logic        step_cmd;

    assign is_halt  = (i_instruction[`INST_BITS-1 -: `OPCODE_BITS] == `HALT_OPCODE);
    assign exit_cmd = (state == st_wait_cmd) && i_rx_done && (i_rx_data == cmd_exit);
    assign step_cmd = (state == st_wait_cmd) && i_rx_done && (i_rx_data == cmd_step);

    assign o_enable     = (state == st_step);
    assign o_send_start = (state == st_dump);
    // processor is frozen during the dump, so if/id still holds the stepped fetch
    assign o_done       = exit_cmd || ((state == st_wait_dump) && i_send_done && is_halt);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= st_idle;
            o_clk_count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (i_start) begin
                        state       <= st_wait_cmd;
                        o_clk_count <= '0;
                    end
                end
                st_wait_cmd: begin
                    if (step_cmd)
                        state <= st_step;
                    else if (exit_cmd)
                        state <= st_idle;
                end
                st_step: begin
                    o_clk_count <= o_clk_count + 1'b1;
                    state       <= st_dump;
                end
                st_dump: state <= st_wait_dump;
                st_wait_dump: begin
                    if (i_send_done)
                        state <= is_halt ? st_idle : st_wait_cmd;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== run_fsm.sv ====
`default_nettype none

`include "debug_params.svh"

module run_fsm
    import debug_cmd_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_start,
    input  logic                       i_send_done,
    input  logic [`INST_BITS-1:0]      i_instruction,
    output logic                       o_enable,
    output logic                       o_send_start,
    output logic [`CLK_COUNT_BITS-1:0] o_clk_count,
    output logic                       o_done
);

    run_state_e state;
    logic       is_halt;

    assign is_halt = (i_instruction[`INST_BITS-1 -: `OPCODE_BITS] == `HALT_OPCODE);

    // processor advances until halt reaches if/id
    assign o_enable     = (state == run_running) && !is_halt;
    assign o_send_start = (state == run_running) && is_halt;
    assign o_done       = (state == run_finish);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= run_idle;
            o_clk_count <= '0;
        end else begin
            case (state)
                run_idle: begin
                    if (i_start) begin
                        state       <= run_running;
                        o_clk_count <= '0;
                    end
                end
                run_running: begin
                    if (is_halt)
                        state <= run_dumping;
                    else
                        o_clk_count <= o_clk_count + 1'b1;
                end
                run_dumping: begin
                    if (i_send_done)
                        state <= run_finish;
                end
                default: state <= run_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== load_inst_fsm.sv ====
`default_nettype none

`include "debug_params.svh"

module load_inst_fsm
    import debug_cmd_pkg::*;
    import cpu_view_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_start,
    input  logic                  i_rx_done,
    input  logic [`UART_BITS-1:0] i_rx_data,
    output logic                  o_imem_wr_valid,
    output imem_write_t           o_imem_wr,
    output logic                  o_done
);

    load_state_e           state;
    logic [1:0]            byte_cnt;
    logic [`PC_BITS-1:0]   addr_cnt;
    logic [`INST_BITS-1:0] word_sr;
    logic                  is_halt;

    assign is_halt = (word_sr[`INST_BITS-1 -: `OPCODE_BITS] == `HALT_OPCODE);

    assign o_imem_wr_valid = (state == ld_write);
    assign o_imem_wr       = '{addr: addr_cnt, data: word_sr};
    assign o_done          = (state == ld_write) && is_halt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= ld_idle;
            byte_cnt <= '0;
            addr_cnt <= '0;
        end else begin
            case (state)
                ld_idle: begin
                    if (i_start) begin
                        state    <= ld_recv;
                        byte_cnt <= '0;
                        addr_cnt <= '0;
                    end
                end
                ld_recv: begin
                    if (i_rx_done) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3)
                            state <= ld_write;
                    end
                end
                ld_write: begin
                    addr_cnt <= addr_cnt + 1'b1;
                    state    <= is_halt ? ld_idle : ld_recv;
                end
                default: state <= ld_idle;
            endcase
        end
    end

    // msb first, so older bytes shift up
    always_ff @(posedge clk) begin
        if (state == ld_recv && i_rx_done)
            word_sr <= {word_sr[`INST_BITS-`UART_BITS-1:0], i_rx_data};
    end

endmodule

`default_nettype wire

// ==== cpu_view_pkg.sv ====
`default_nettype none

`include "debug_params.svh"

package cpu_view_pkg;

    // processor state as seen by the debug unit
    typedef struct packed {
        logic [`NUM_REGS-1:0][`PROC_BITS-1:0] rf_regs;
        logic [`INST_BITS-1:0]                if_id;
        logic [`PROC_BITS-1:0]                id_ex;
        logic [`PROC_BITS-1:0]                ex_mem;
        logic [`PROC_BITS-1:0]                mem_wb;
    } cpu_snapshot_t;

    // one instruction memory write, valid travels on its own port
    typedef struct packed {
        logic [`PC_BITS-1:0]   addr;
        logic [`INST_BITS-1:0] data;
    } imem_write_t;

endpackage

`default_nettype wire

// ==== debug_cmd_pkg.sv ====
`default_nettype none

`include "debug_params.svh"

package debug_cmd_pkg;

    typedef enum logic [`UART_BITS-1:0] {
        cmd_load      = `CMD_LOAD,
        cmd_run       = `CMD_RUN,
        cmd_step_mode = `CMD_STEP_MODE,
        cmd_step      = `CMD_STEP,
        cmd_exit      = `CMD_EXIT
    } debug_cmd_e;

    // top level controller
    typedef enum logic [2:0] {
        idle       = 3'd0,
        start_load = 3'd1,
        wait_load  = 3'd2,
        start_run  = 3'd3,
        wait_run   = 3'd4,
        start_step = 3'd5,
        wait_step  = 3'd6
    } debug_state_e;

    // sub-machines
    typedef enum logic [1:0] {ld_idle, ld_recv, ld_write} load_state_e;
    typedef enum logic [1:0] {run_idle, run_running, run_dumping, run_finish} run_state_e;
    typedef enum logic [2:0] {st_idle, st_wait_cmd, st_step, st_dump, st_wait_dump} step_state_e;
    typedef enum logic [2:0] {sd_idle, sd_fetch, sd_mem, sd_send, sd_wait, sd_done} send_state_e;

endpackage

`default_nettype wire

// ==== debug_params.svh ====
`ifndef DEBUG_PARAMS_SVH
`define DEBUG_PARAMS_SVH

// uart and processor widths
`define UART_BITS       8
`define PC_BITS         8
`define INST_BITS       32
`define PROC_BITS       32
`define DATA_ADDR_BITS  5

// dump contents
`define NUM_REGS        8
`define DUMP_MEM_WORDS  8
`define CLK_COUNT_BITS  16

// halt sits in the top six instruction bits
`define OPCODE_BITS     6
`define HALT_OPCODE     6'b111111

// host command bytes
`define CMD_LOAD        8'd1
`define CMD_RUN         8'd2
`define CMD_STEP_MODE   8'd3
`define CMD_STEP        8'd4
`define CMD_EXIT        8'd5

`endif
